// File: filelist.f
logic/corePkg.sv
logic/csrPkg.sv
logic/regFile.sv
logic/operandFetch.sv
logic/intAlu.sv
logic/divider.sv
logic/csrFile.sv
logic/execCore.sv
verification/execCore_assert.sv
verification/execCoreTb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP       = execCoreTb
FILELIST  = filelist.f
OBJDIR    = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "All tests passed!" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: verification/execCoreTb.sv
`timescale 1ns/10ps

module execCoreTb;

import corePkg::*;
import csrPkg::*;

localparam int CLK_PERIOD = 8;
localparam int N_ALU = 160;
localparam int N_DIV = 24;
localparam int N_CSR = 40;
localparam int TIMEOUT_CYCLES = 4 + 32 * 2 + N_ALU * 2 + (N_DIV + 8) * (DIV_STEPS + 12)
    + N_CSR * 2 + 300;

logic clk = 1'b0;
logic rst;
IssueUop uop;
logic uopValid;
logic uopReady;
WbResult wb;
ApbReq apbReq;
ApbResp apbResp;

logic [15:0] lfsr = 16'd52396;
logic [XLEN-1:0] model [32];
logic [XLEN-1:0] modelScratch;
logic [XLEN-1:0] expData [16];
logic [REG_ADDR_W-1:0] expRd [16];
int expCyc [16];
logic expPend [16];
logic expDiv [16];
string expName [16];
int cyc = 0;
int wbCount;
logic divOpen;
logic prevFired;
logic [REG_ADDR_W-1:0] prevRd;
logic [OP_ID_W-1:0] nextId;

execCore execCore_inst
(
    .clk(clk),
    .rst(rst),
    .uop(uop),
    .uopValid(uopValid),
    .uopReady(uopReady),
    .wb(wb),
    .apbReq(apbReq),
    .apbResp(apbResp)
);

always #(CLK_PERIOD / 2) clk = ~clk;

always @(posedge clk) cyc <= cyc + 1;

task automatic failNow(input string msg);
    $display("%s", msg);
    $display("Test failures found");
    $fatal(1);
endtask

task automatic reportMismatch(input string name, input logic [31:0] expected,
    input logic [31:0] actual);
    failNow($sformatf("** Error %s: expected 0x%h, actual 0x%h", name, expected, actual));
endtask

// galois form, taps 16 14 13 11
function automatic logic [15:0] lfsrNext(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
endfunction

function automatic logic [31:0] randBits(input int n);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < n; i++) begin
        bits = {bits[30:0], lfsr[0]};
        lfsr = lfsrNext(lfsr);
    end
    return bits;
endfunction

function automatic logic [XLEN-1:0] refResult(input FuType fu, input logic [3:0] op,
    input logic [XLEN-1:0] a, input logic [XLEN-1:0] b, input logic [XLEN-1:0] scr);
    logic signed [XLEN-1:0] sa;
    logic signed [XLEN-1:0] sb;
    logic ovf;
    sa = a;
    sb = b;
    ovf = a == 32'h8000_0000 && b == 32'hFFFF_FFFF;
    if (fu == FU_CSR)
        return scr;  // old value of scratch
    if (fu == FU_DIV) begin
        case (DivOp'(op[1:0]))
            DIV_DIV:  if (b == '0) return '1; else if (ovf) return a; else return sa / sb;
            DIV_DIVU: if (b == '0) return '1; else return a / b;
            DIV_REM:  if (b == '0) return a; else if (ovf) return '0; else return sa % sb;
            default:  if (b == '0) return a; else return a % b;
        endcase
    end
    case (AluOp'(op))
        ALU_ADD:  return a + b;
        ALU_SUB:  return a - b;
        ALU_AND:  return a & b;
        ALU_OR:   return a | b;
        ALU_XOR:  return a ^ b;
        ALU_SLL:  return a << b[4:0];
        ALU_SRL:  return a >> b[4:0];
        ALU_SRA:  return sa >>> b[4:0];
        ALU_SLT:  return (sa < sb) ? 32'd1 : 32'd0;
        ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
        default:  return '0;
    endcase
endfunction

// funct3 bit 2 picks zimm, low bits pick write/set/clear
function automatic logic [XLEN-1:0] csrNext(input logic [2:0] op, input logic [XLEN-1:0] scr,
    input logic [XLEN-1:0] a, input logic [4:0] zimm);
    logic [XLEN-1:0] operand;
    operand = op[2] ? {27'd0, zimm} : a;
    case (op[1:0])
        2'd1:    return operand;
        2'd2:    return scr | operand;
        2'd3:    return scr & ~operand;
        default: return scr;
    endcase
endfunction

function automatic IssueUop makeUop(input FuType fu, input logic [3:0] op, input int rs1,
    input int rs2, input int rd, input logic useImm, input logic [31:0] imm);
    IssueUop u;
    u = '0;
    u.fu = fu;
    u.op = op;
    u.rs1 = 5'(rs1);
    u.rs2 = 5'(rs2);
    u.rd = 5'(rd);
    u.useImm = useImm;
    u.imm.full = imm;
    return u;
endfunction

function automatic int pendingCount();
    int n;
    n = 0;
    for (int i = 0; i < 16; i++) begin
        if (expPend[i])
            n++;
    end
    return n;
endfunction

task automatic issueOp(input IssueUop u, input string name);
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    if (prevFired && prevRd != '0 && (u.rs1 == prevRd || (!u.useImm && u.rs2 == prevRd))) begin
        uopValid = 1'b0;  // one bubble moves the dependency onto the wb bypass
        prevFired = 1'b0;
        @(negedge clk);
    end
    assert (!(divOpen && uopReady)) else failNow("uopReady high while a divide is pending");
    while (!uopReady) begin
        uopValid = 1'b0;
        prevFired = 1'b0;
        @(negedge clk);
        assert (!(divOpen && uopReady)) else failNow("uopReady high while a divide is pending");
    end
    u.opId = nextId;
    nextId = nextId + 1'b1;
    a = model[u.rs1];
    b = u.useImm ? u.imm.full : model[u.rs2];
    expData[u.opId] = refResult(u.fu, u.op, a, b, modelScratch);
    expRd[u.opId] = u.rd;
    expCyc[u.opId] = cyc + ((u.fu == FU_DIV) ? DIV_STEPS + 2 : 2);
    expDiv[u.opId] = u.fu == FU_DIV;
    expName[u.opId] = name;
    expPend[u.opId] = 1'b1;
    if (u.fu == FU_CSR)
        modelScratch = csrNext(u.op[2:0], modelScratch, a, u.imm.csr.zimm);
    if (u.rd != '0)
        model[u.rd] = expData[u.opId];
    if (u.fu == FU_DIV)
        divOpen = 1'b1;
    uop = u;
    uopValid = 1'b1;
    prevFired = 1'b1;
    prevRd = u.rd;
    @(negedge clk);
    uopValid = 1'b0;
endtask

task automatic divCase(input logic [1:0] op, input logic [31:0] a, input logic [31:0] b,
    input string name);
    issueOp(makeUop(FU_ALU, ALU_ADD, 0, 0, 1, 1'b1, a), "div operand a");
    issueOp(makeUop(FU_ALU, ALU_ADD, 0, 0, 2, 1'b1, b), "div operand b");
    issueOp(makeUop(FU_ALU, ALU_SUB, 1, 0, 6, 1'b1, 32'd7), "alu before div");
    issueOp(makeUop(FU_DIV, {2'b00, op}, 1, 2, 3, 1'b0, 32'd0), name);
endtask

task automatic apbAccess(input logic wr, input logic [11:0] addr, input logic [XLEN-1:0] wdata,
    output logic [XLEN-1:0] rdata, output logic err);
    apbReq.psel = 1'b1;
    apbReq.penable = 1'b0;
    apbReq.pwrite = wr;
    apbReq.paddr = addr;
    apbReq.pwdata = wdata;
    @(negedge clk);
    apbReq.penable = 1'b1;
    #1;  // let pready settle
    while (!apbResp.pready) begin
        @(negedge clk);
        #1;
    end
    rdata = apbResp.prdata;
    err = apbResp.pslverr;
    @(negedge clk);  // access completed on the edge in between
    apbReq = '0;
endtask

always @(negedge clk) begin
    logic [OP_ID_W-1:0] id;
    if (!rst && wb.valid) begin
        id = wb.opId;
        wbCount++;
        assert (expPend[id]) else failNow($sformatf("writeback for opId %0d not pending", id));
        assert (wb.rd == expRd[id]) else reportMismatch({expName[id], " rd"}, expRd[id], wb.rd);
        assert (wb.result == expData[id]) else reportMismatch(expName[id], expData[id], wb.result);
        if (expDiv[id]) begin
            assert (cyc >= expCyc[id]) else reportMismatch("divide latency", expCyc[id], cyc);
            divOpen = 1'b0;
        end else begin
            assert (cyc == expCyc[id])
                else reportMismatch({expName[id], " latency"}, expCyc[id], cyc);
        end
        expPend[id] = 1'b0;
    end
end

initial begin
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    failNow("watchdog timeout, the run did not complete in time");
end

initial begin
    IssueUop u;
    logic [2:0] pick;
    logic [XLEN-1:0] rdata;
    logic [XLEN-1:0] firstCycle;
    logic err;
    rst = 1'b1;
    uop = '0;
    uopValid = 1'b0;
    apbReq = '0;
    modelScratch = '0;
    wbCount = 0;
    divOpen = 1'b0;
    prevFired = 1'b0;
    prevRd = '0;
    nextId = '0;
    for (int i = 0; i < 32; i++)
        model[i] = '0;
    for (int i = 0; i < 16; i++) begin
        expPend[i] = 1'b0;
        expDiv[i] = 1'b0;
    end
    repeat (4) @(negedge clk);
    rst = 1'b0;

    assert (uopReady && !wb.valid && !apbResp.pready) else failNow("outputs not at reset values");
    for (int r = 0; r < 32; r++)
        issueOp(makeUop(FU_ALU, ALU_ADD, r, 0, 0, 1'b0, 32'd0), "reset register read");

    for (int n = 0; n < N_ALU; n++) begin
        u = makeUop(FU_ALU, 4'(randBits(4) % 10), randBits(3), randBits(3), randBits(3),
            randBits(1), randBits(32));
        issueOp(u, "random alu");
    end
    issueOp(makeUop(FU_ALU, ALU_ADD, 0, 0, 0, 1'b1, 32'h55), "x0 write");
    @(negedge clk);  // next read lands while the x0 write is on wb
    issueOp(makeUop(FU_ALU, ALU_OR, 0, 0, 7, 1'b0, 32'd0), "x0 read on bypass");
    issueOp(makeUop(FU_ALU, ALU_OR, 0, 0, 7, 1'b0, 32'd0), "x0 read from regfile");

    for (int op = 0; op < 4; op++) begin
        divCase(2'(op), randBits(32), 32'd0, "divide by zero");
        divCase(2'(op), 32'h8000_0000, 32'hFFFF_FFFF, "divide overflow");
    end
    for (int n = 0; n < N_DIV; n++)
        divCase(2'(randBits(2)), randBits(32), randBits(1) ? randBits(32) : randBits(8),
            "random div");

    for (int n = 0; n < N_CSR; n++) begin
        pick = 3'(randBits(3));
        if (pick[1:0] == 2'd0)
            pick[1:0] = 2'd1;  // no funct3 0 or 4 in the csr set
        u = makeUop(FU_CSR, {1'b0, pick}, randBits(3), 0, randBits(3), 1'b0, 32'd0);
        u.imm.csr.csrAddr = CSR_SCRATCH;
        u.imm.csr.zimm = 5'(randBits(5));
        issueOp(u, "csr scratch");
    end

    while (pendingCount() != 0)
        @(negedge clk);
    repeat (4) @(negedge clk);

    apbAccess(1'b0, CSR_SCRATCH, '0, rdata, err);
    assert (rdata == modelScratch) else reportMismatch("apb scratch after csr", modelScratch, rdata);
    apbAccess(1'b1, CSR_SCRATCH, 32'hA5C3_0F1E, rdata, err);
    assert (!err) else failNow("pslverr on a write to scratch");
    apbAccess(1'b0, CSR_SCRATCH, '0, rdata, err);
    assert (rdata == 32'hA5C3_0F1E)
        else reportMismatch("apb scratch readback", 32'hA5C3_0F1E, rdata);
    apbAccess(1'b1, CSR_CYCLE, 32'h1234, rdata, err);
    assert (err) else failNow("no pslverr on a write to the cycle counter");
    apbAccess(1'b1, CSR_RETIRED, 32'h1234, rdata, err);
    assert (err) else failNow("no pslverr on a write to the retired counter");
    apbAccess(1'b0, 12'h123, '0, rdata, err);
    assert (err) else failNow("no pslverr on an unknown address");
    apbAccess(1'b0, CSR_RETIRED, '0, rdata, err);
    assert (rdata == wbCount) else reportMismatch("apb retired count", wbCount, rdata);
    apbAccess(1'b0, CSR_CYCLE, '0, firstCycle, err);
    apbAccess(1'b0, CSR_CYCLE, '0, rdata, err);
    assert (rdata > firstCycle) else failNow("cycle counter did not increase between two reads");

    repeat (2) @(negedge clk);
    if (pendingCount() == 0) begin
        $display("All tests passed!");
        $finish;
    end else begin
        failNow($sformatf("%0d writebacks never arrived", pendingCount()));
    end
end

endmodule

// File: verification/execCore_assert.sv
`timescale 1ns/10ps

module execCore_assert
(
    input logic clk,
    input logic rst,
    input logic uopReady,
    input corePkg::WbResult divRes,
    input corePkg::WbResult wb,
    input csrPkg::ApbReq apbReq,
    input csrPkg::ApbResp apbResp
);

// divider is single entry
divBlocksIssue: assert property (@(posedge clk) disable iff (rst)
    divRes.valid |-> !uopReady)
    else $error("uopReady high while the divider holds a result");

apbAccessHolds: assert property (@(posedge clk) disable iff (rst)
    apbReq.psel && apbReq.penable && !apbResp.pready |=>
        apbReq.psel && $stable(apbReq.paddr) && $stable(apbReq.pwrite))
    else $error("APB request changed before pready");

wbIdleQuiet: assert property (@(posedge clk) disable iff (rst)
    !wb.valid |-> wb.rd == '0)
    else $error("wb.rd nonzero without wb.valid");

endmodule

bind execCore execCore_assert execCoreAssert_inst
(
    .clk(clk),
    .rst(rst),
    .uopReady(uopReady),
    .divRes(divRes),
    .wb(wb),
    .apbReq(apbReq),
    .apbResp(apbResp)
);

// File: logic/execCore.sv
`timescale 1ns/10ps

module execCore
(
    input  logic clk,
    input  logic rst,

    input  corePkg::IssueUop uop,
    input  logic uopValid,
    output logic uopReady,

    output corePkg::WbResult wb,

    input  csrPkg::ApbReq apbReq,
    output csrPkg::ApbResp apbResp
);

import corePkg::*;

ExecUop exUop;
WbResult aluRes;
WbResult csrRes;
WbResult divRes;
logic divBusy;
logic divPending;
logic fire;
logic wbTaken;

// divider is single entry, hold issue until it drains
assign uopReady = !(divBusy || divRes.valid || divPending);
assign fire = uopValid && uopReady;

operandFetch opFetch
(
    .clk(clk),
    .rst(rst),
    .uop(uop),
    .fire(fire),
    .wbIn(wb),
    .execUop(exUop),
    .divPending(divPending)
);

intAlu alu
(
    .clk(clk),
    .rst(rst),
    .execUop(exUop),
    .result(aluRes)
);

divider div
(
    .clk(clk),
    .rst(rst),
    .execUop(exUop),
    .wbTaken(wbTaken),
    .busy(divBusy),
    .result(divRes)
);

csrFile csr
(
    .clk(clk),
    .rst(rst),
    .execUop(exUop),
    .wbFire(wb.valid),
    .apbReq(apbReq),
    .apbResp(apbResp),
    .result(csrRes)
);

assign wbTaken = divRes.valid && !aluRes.valid && !csrRes.valid;

always_comb begin
    if (aluRes.valid)
        wb = aluRes;
    else if (csrRes.valid)
        wb = csrRes;
    else if (divRes.valid)
        wb = divRes;
    else
        wb = '0;  // idle bus
end

endmodule

// File: logic/csrFile.sv
`timescale 1ns/10ps

module csrFile
(
    input  logic clk,
    input  logic rst,
    input  corePkg::ExecUop execUop,
    input  logic wbFire,
    input  csrPkg::ApbReq apbReq,
    output csrPkg::ApbResp apbResp,
    output corePkg::WbResult result
);

import corePkg::*;
import csrPkg::*;

CsrOp op;
logic uopHit;
logic [11:0] uopAddr;
logic [XLEN-1:0] scratch;
logic [XLEN-1:0] cycleCnt;
logic [XLEN-1:0] retiredCnt;
logic [XLEN-1:0] oldVal;
logic [XLEN-1:0] operand;
logic [XLEN-1:0] newScratch;
logic apbWrScratch;

function automatic logic [XLEN-1:0] csrMux(
    input logic [11:0] addr,
    input logic [XLEN-1:0] scr,
    input logic [XLEN-1:0] cyc,
    input logic [XLEN-1:0] ret
);
    case (addr)
        CSR_SCRATCH: return scr;
        CSR_CYCLE:   return cyc;
        CSR_RETIRED: return ret;
        default:     return '0;
    endcase
endfunction

assign op = CsrOp'(execUop.op[2:0]);
assign uopHit = execUop.valid && execUop.fu == FU_CSR;
assign uopAddr = execUop.imm.csr.csrAddr;
assign oldVal = csrMux(uopAddr, scratch, cycleCnt, retiredCnt);
assign operand = (op inside {CSR_RWI, CSR_RSI, CSR_RCI}) ?
    XLEN'(execUop.imm.csr.zimm) : execUop.srcA;

always_comb begin
    case (op)
        CSR_RW, CSR_RWI: newScratch = operand;
        CSR_RS, CSR_RSI: newScratch = scratch | operand;
        CSR_RC, CSR_RCI: newScratch = scratch & ~operand;
        default:         newScratch = scratch;
    endcase
end

// micro-op owns the cycle, APB waits
assign apbResp.pready = apbReq.psel && apbReq.penable && !uopHit;
assign apbResp.prdata = csrMux(apbReq.paddr, scratch, cycleCnt, retiredCnt);
assign apbResp.pslverr = !(apbReq.paddr inside {CSR_SCRATCH, CSR_CYCLE, CSR_RETIRED})
    || (apbReq.pwrite && apbReq.paddr != CSR_SCRATCH);
assign apbWrScratch = apbResp.pready && apbReq.pwrite && apbReq.paddr == CSR_SCRATCH;

always_ff @(posedge clk) begin
    if (rst) begin
        scratch <= '0;
        cycleCnt <= '0;
        retiredCnt <= '0;
        result.valid <= 1'b0;
    end else begin
        cycleCnt <= cycleCnt + 1'b1;
        if (wbFire)
            retiredCnt <= retiredCnt + 1'b1;
        if (uopHit && uopAddr == CSR_SCRATCH)
            scratch <= newScratch;
        else if (apbWrScratch)
            scratch <= apbReq.pwdata;
        result.valid <= uopHit;
    end

    if (uopHit) begin
        result.rd <= execUop.rd;
        result.opId <= execUop.opId;
        result.result <= oldVal;  // csr ops return the old value
    end
end

endmodule

// File: logic/divider.sv
`timescale 1ns/10ps

module divider
(
    input  logic clk,
    input  logic rst,
    input  corePkg::ExecUop execUop,
    input  logic wbTaken,
    output logic busy,
    output corePkg::WbResult result
);

import corePkg::*;

DivOp op;
logic start;
logic isSigned;
logic lastStep;
logic [DIV_CNT_W-1:0] count;
logic [XLEN-1:0] rem;
logic [XLEN-1:0] quo;       // dividend shifts out as quotient shifts in
logic [XLEN-1:0] divisor;
logic negQ;
logic negR;
logic wantRem;
logic [XLEN:0] shifted;
logic [XLEN:0] diff;
logic [XLEN-1:0] nextRem;
logic [XLEN-1:0] nextQuo;

assign op = DivOp'(execUop.op[1:0]);
assign start = execUop.valid && execUop.fu == FU_DIV;
assign isSigned = (op == DIV_DIV) || (op == DIV_REM);
assign lastStep = count == DIV_CNT_W'(DIV_STEPS - 1);

// one restoring step
assign shifted = {rem, quo[XLEN-1]};
assign diff = shifted - {1'b0, divisor};
assign nextRem = diff[XLEN] ? shifted[XLEN-1:0] : diff[XLEN-1:0];
assign nextQuo = {quo[XLEN-2:0], ~diff[XLEN]};

always_ff @(posedge clk) begin
    if (rst) begin
        busy <= 1'b0;
        count <= '0;
        result.valid <= 1'b0;
    end else begin
        if (start) begin
            busy <= 1'b1;
            count <= '0;
        end else if (busy) begin
            count <= count + 1'b1;
            if (lastStep) begin
                busy <= 1'b0;
                result.valid <= 1'b1;
            end
        end
        if (wbTaken)
            result.valid <= 1'b0;
    end

    if (start) begin
        rem <= '0;
        quo <= (isSigned && execUop.srcA[XLEN-1]) ? -execUop.srcA : execUop.srcA;
        divisor <= (isSigned && execUop.srcB[XLEN-1]) ? -execUop.srcB : execUop.srcB;
        // x/0 keeps all ones, MIN/-1 falls out of the magnitudes
        negQ <= isSigned && (execUop.srcA[XLEN-1] ^ execUop.srcB[XLEN-1])
            && execUop.srcB != '0;
        negR <= isSigned && execUop.srcA[XLEN-1];
        wantRem <= (op == DIV_REM) || (op == DIV_REMU);
        result.rd <= execUop.rd;
        result.opId <= execUop.opId;
    end else if (busy) begin
        rem <= nextRem;
        quo <= nextQuo;
        if (lastStep) begin
            if (wantRem)
                result.result <= negR ? -nextRem : nextRem;
            else
                result.result <= negQ ? -nextQuo : nextQuo;
        end
    end
end

endmodule

// File: logic/intAlu.sv
`timescale 1ns/10ps

module intAlu
(
    input  logic clk,
    input  logic rst,
    input  corePkg::ExecUop execUop,
    output corePkg::WbResult result
);

import corePkg::*;

logic [XLEN-1:0] a;
logic [XLEN-1:0] b;
logic [4:0] shamt;
logic [XLEN-1:0] aluOut;
logic hit;

assign a = execUop.srcA;
assign b = execUop.srcB;
assign shamt = b[4:0];
assign hit = execUop.valid && execUop.fu == FU_ALU;

always_comb begin
    case (AluOp'(execUop.op))
        ALU_ADD:  aluOut = a + b;
        ALU_SUB:  aluOut = a - b;
        ALU_AND:  aluOut = a & b;
        ALU_OR:   aluOut = a | b;
        ALU_XOR:  aluOut = a ^ b;
        ALU_SLL:  aluOut = a << shamt;
        ALU_SRL:  aluOut = a >> shamt;
        ALU_SRA:  aluOut = $signed(a) >>> shamt;
        ALU_SLT:  aluOut = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
        ALU_SLTU: aluOut = {{(XLEN-1){1'b0}}, a < b};
        default:  aluOut = '0;
    endcase
end

always_ff @(posedge clk) begin
    if (rst)
        result.valid <= 1'b0;
    else
        result.valid <= hit;

    if (hit) begin
        result.rd     <= execUop.rd;
        result.opId   <= execUop.opId;
        result.result <= aluOut;
    end
end

endmodule

// File: logic/operandFetch.sv
`timescale 1ns/10ps

module operandFetch
(
    input  logic clk,
    input  logic rst,
    input  corePkg::IssueUop uop,
    input  logic fire,
    input  corePkg::WbResult wbIn,
    output corePkg::ExecUop execUop,
    output logic divPending
);

import corePkg::*;

logic [XLEN-1:0] rfData1;
logic [XLEN-1:0] rfData2;
logic [XLEN-1:0] src1;
logic [XLEN-1:0] src2;

function automatic logic [XLEN-1:0] bypass(
    input logic [REG_ADDR_W-1:0] addr,
    input logic [XLEN-1:0] rfData,
    input WbResult wbRes
);
    if (wbRes.valid && wbRes.rd != '0 && wbRes.rd == addr)
        return wbRes.result;  // written back this same cycle
    return rfData;
endfunction

regFile rf
(
    .clk(clk),
    .wbIn(wbIn),
    .rs1Addr(uop.rs1),
    .rs2Addr(uop.rs2),
    .rs1Data(rfData1),
    .rs2Data(rfData2)
);

assign src1 = bypass(uop.rs1, rfData1, wbIn);
assign src2 = uop.useImm ? uop.imm.full : bypass(uop.rs2, rfData2, wbIn);

always_ff @(posedge clk) begin
    if (rst)
        execUop.valid <= 1'b0;
    else
        execUop.valid <= fire;

    if (fire) begin
        execUop.fu   <= uop.fu;
        execUop.op   <= uop.op;
        execUop.rd   <= uop.rd;
        execUop.opId <= uop.opId;
        execUop.srcA <= src1;
        execUop.srcB <= src2;
        execUop.imm  <= uop.imm;
    end
end

assign divPending = execUop.valid && execUop.fu == FU_DIV;

endmodule

// File: logic/regFile.sv
`timescale 1ns/10ps

module regFile
(
    input  logic clk,
    input  corePkg::WbResult wbIn,
    input  logic [corePkg::REG_ADDR_W-1:0] rs1Addr,
    input  logic [corePkg::REG_ADDR_W-1:0] rs2Addr,
    output logic [corePkg::XLEN-1:0] rs1Data,
    output logic [corePkg::XLEN-1:0] rs2Data
);

import corePkg::*;

logic [XLEN-1:0] regs [2**REG_ADDR_W];

// power-up contents, x0 is never written afterwards
initial begin
    for (int i = 0; i < 2**REG_ADDR_W; i++) begin
        regs[i] = '0;
    end
end

always_ff @(posedge clk) begin
    if (wbIn.valid && wbIn.rd != '0) begin
        regs[wbIn.rd] <= wbIn.result;
    end
end

assign rs1Data = regs[rs1Addr];
assign rs2Data = regs[rs2Addr];

endmodule

// File: logic/csrPkg.sv
package csrPkg;

    localparam logic [11:0] CSR_SCRATCH = 12'h340;
    localparam logic [11:0] CSR_CYCLE   = 12'hC00;  // read only
    localparam logic [11:0] CSR_RETIRED = 12'hC02;  // read only

    // funct3 encoding
    typedef enum logic [2:0] {
        CSR_RW  = 3'd1,
        CSR_RS  = 3'd2,
        CSR_RC  = 3'd3,
        CSR_RWI = 3'd5,
        CSR_RSI = 3'd6,
        CSR_RCI = 3'd7
    } CsrOp;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [11:0] paddr;
        logic [31:0] pwdata;
    } ApbReq;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } ApbResp;

endpackage

// File: logic/corePkg.sv
package corePkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int OP_ID_W    = 4;
    localparam int DIV_STEPS  = 32;
    localparam int DIV_CNT_W  = $clog2(DIV_STEPS);

    typedef enum logic [1:0] {
        FU_ALU = 2'd0,
        FU_DIV = 2'd1,
        FU_CSR = 2'd2
    } FuType;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9
    } AluOp;

    typedef enum logic [1:0] {
        DIV_DIV  = 2'd0,
        DIV_DIVU = 2'd1,
        DIV_REM  = 2'd2,
        DIV_REMU = 2'd3
    } DivOp;

    // same bit positions as csr and rs1 in the instruction word
    typedef struct packed {
        logic [11:0] csrAddr;
        logic [4:0]  zimm;
        logic [14:0] pad;
    } CsrImm;

    typedef union packed {
        logic [XLEN-1:0] full;
        CsrImm           csr;
    } ImmWord;

    typedef struct packed {
        FuType                 fu;
        logic [3:0]            op;     // AluOp, DivOp or CsrOp by fu
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rd;
        logic                  useImm;
        ImmWord                imm;
        logic [OP_ID_W-1:0]    opId;
    } IssueUop;

    typedef struct packed {
        logic                  valid;
        FuType                 fu;
        logic [3:0]            op;
        logic [REG_ADDR_W-1:0] rd;
        logic [OP_ID_W-1:0]    opId;
        logic [XLEN-1:0]       srcA;
        logic [XLEN-1:0]       srcB;
        ImmWord                imm;
    } ExecUop;

    typedef struct packed {
        logic                  valid;
        logic [REG_ADDR_W-1:0] rd;
        logic [OP_ID_W-1:0]    opId;
        logic [XLEN-1:0]       result;
    } WbResult;

endpackage
